/* src/soc_defines.svh */
// Bus widths, region codes, register index width and divisor reset values
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

`define FB_AW        32      // Bus address width
`define FB_DW        32      // Bus data width
`define FB_NBYTE     4       // Write-mask bits, one per byte lane

// Top address byte of each peripheral window
`define SPI_REGION   8'h80
`define UART_REGION  8'h81

`define REG_IDX_W    2       // Register index from addr[3:2]

`define UART_DIV_RST 16'd16  // Clocks per UART bit
`define SPI_DIV_RST  8'd4    // Clocks per SCK half period

`endif

/* src/soc_bus_pkg.sv */
// Frontend bus address, request and response structs and target-select enum
`default_nettype none
`include "soc_defines.svh"

package soc_bus_pkg;

   // Address as the router and register blocks split it
   typedef struct packed {
      logic [7:0]         region;  // Peripheral window
      logic [`FB_AW-11:0] offset;  // Word offset in window
      logic [1:0]         lane;    // Byte in word
   } fb_addr_t;

   // Request channel payload
   typedef struct packed {
      fb_addr_t              addr;
      logic [`FB_NBYTE-1:0]  wmsk;   // Nonzero marks a write
      logic [`FB_DW-1:0]     wdata;
   } fb_req_t;

   // Response channel payload
   typedef struct packed {
      logic [`FB_DW-1:0] rdata;
   } fb_rsp_t;

   typedef enum logic [1:0] {
      TGT_SPI,
      TGT_UART,
      TGT_NONE                       // Unmapped region
   } fb_target_e;

endpackage

`default_nettype wire

/* src/soc_periph_pkg.sv */
// Register index enum and peripheral control and status structs
`default_nettype none
`include "soc_defines.svh"

package soc_periph_pkg;

   // Register index, addr[3:2]
   typedef enum logic [`REG_IDX_W-1:0] {
      REG_DATA   = 2'd0,
      REG_STATUS = 2'd1,
      REG_CTRL   = 2'd2,
      REG_DIV    = 2'd3
   } reg_idx_e;

   typedef struct packed {
      logic tx_done;   // Bit 1, write 1 to clear
      logic busy;      // Bit 0
   } uart_status_t;

   typedef struct packed {
      logic irq_en;
   } uart_ctrl_t;

   typedef struct packed {
      logic busy;
   } spi_status_t;

   typedef struct packed {
      logic cs_active;  // Drives SPI_CS_L low
   } spi_ctrl_t;

endpackage

`default_nettype wire

/* src/pb_fb_router.sv */
// Frontend bus router with region decode, response mux and unmapped responder
`timescale 1ns/1ps
`default_nettype none
`include "soc_defines.svh"

module pb_fb_router
   import soc_bus_pkg::*;
(
   input  wire          CPU_CLK,
   input  wire          rst_n,
   // Master side
   input  wire          req_valid,
   output logic         req_ready,
   input  wire fb_req_t req,
   output logic         rsp_valid,
   input  wire          rsp_ready,
   output fb_rsp_t      rsp,
   // SPI register block
   output logic         spi_req_valid,
   input  wire          spi_req_ready,
   output fb_req_t      spi_req,
   input  wire          spi_rsp_valid,
   output logic         spi_rsp_ready,
   input  wire fb_rsp_t spi_rsp,
   // UART register block
   output logic         uart_req_valid,
   input  wire          uart_req_ready,
   output fb_req_t      uart_req,
   input  wire          uart_rsp_valid,
   output logic         uart_rsp_ready,
   input  wire fb_rsp_t uart_rsp
);

   fb_target_e tgt_sel;  // Decode of incoming request
   fb_target_e tgt_q;    // Target of outstanding request
   logic       pend_q;   // Accepted, response not yet returned
   logic       open_q;   // Set once out of reset
   logic       idle;
   logic       tgt_rdy;

   always_comb begin
      case (req.addr.region)
         `SPI_REGION:  tgt_sel = TGT_SPI;
         `UART_REGION: tgt_sel = TGT_UART;
         default:      tgt_sel = TGT_NONE;
      endcase
   end

   always_comb begin
      case (tgt_sel)
         TGT_SPI:  tgt_rdy = spi_req_ready;
         TGT_UART: tgt_rdy = uart_req_ready;
         default:  tgt_rdy = 1'b1;  // Local responder never stalls
      endcase
   end

   // Only one request in flight
   assign idle      = open_q & ~pend_q;
   assign req_ready = idle & tgt_rdy;

   assign spi_req_valid  = req_valid & idle & (tgt_sel == TGT_SPI);
   assign uart_req_valid = req_valid & idle & (tgt_sel == TGT_UART);
   assign spi_req        = req;  // Payload to both, valid selects
   assign uart_req       = req;

   always_comb begin
      case (tgt_q)
         TGT_SPI: begin
            rsp_valid = pend_q & spi_rsp_valid;
            rsp       = spi_rsp;
         end
         TGT_UART: begin
            rsp_valid = pend_q & uart_rsp_valid;
            rsp       = uart_rsp;
         end
         default: begin
            rsp_valid = pend_q;  // Cycle after acceptance
            rsp       = '0;      // Zero read, write dropped
         end
      endcase
   end

   assign spi_rsp_ready  = rsp_ready & pend_q & (tgt_q == TGT_SPI);
   assign uart_rsp_ready = rsp_ready & pend_q & (tgt_q == TGT_UART);

   always_ff @(posedge CPU_CLK or negedge rst_n) begin
      if (!rst_n) begin
         open_q <= 1'b0;
         pend_q <= 1'b0;
         tgt_q  <= TGT_NONE;
      end else begin
         open_q <= 1'b1;
         if (req_valid & req_ready) begin
            pend_q <= 1'b1;
            tgt_q  <= tgt_sel;  // Steers the response back
         end else if (rsp_valid & rsp_ready) begin
            pend_q <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

/* src/uart_tx.sv */
// UART transmit serializer with baud and bit counters
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
   input  wire          CPU_CLK,
   input  wire          rst_n,
   input  wire          tx_start,
   input  wire [7:0]    tx_byte,
   input  wire [15:0]   div,
   output logic         tx_busy,
   output logic         tx_done,
   output logic         UART_TX_L
);

   logic [15:0] baud_cnt;
   logic [3:0]  bit_cnt;   // 0 start, 1..8 data, 9 stop
   logic [9:0]  frame;     // Shifts out from bit 0
   logic        bit_end;

   assign bit_end   = tx_busy & (baud_cnt == div - 16'd1);
   assign UART_TX_L = ~tx_busy | frame[0];  // Idle line high

   always_ff @(posedge CPU_CLK or negedge rst_n) begin
      if (!rst_n) begin
         tx_busy  <= 1'b0;
         tx_done  <= 1'b0;
         baud_cnt <= 16'd0;
         bit_cnt  <= 4'd0;
      end else begin
         tx_done <= 1'b0;
         if (~tx_busy) begin
            if (tx_start) begin
               tx_busy  <= 1'b1;
               baud_cnt <= 16'd0;
               bit_cnt  <= 4'd0;
            end
         end else if (bit_end) begin
            baud_cnt <= 16'd0;
            if (bit_cnt == 4'd9) begin
               tx_busy <= 1'b0;  // Stop bit done
               tx_done <= 1'b1;
            end else begin
               bit_cnt <= bit_cnt + 4'd1;
            end
         end else begin
            baud_cnt <= baud_cnt + 16'd1;
         end
      end
   end

   always_ff @(posedge CPU_CLK) begin
      if (tx_start & ~tx_busy) begin
         frame <= {1'b1, tx_byte, 1'b0};  // Stop, data LSB first, start
      end else if (bit_end) begin
         frame <= {1'b1, frame[9:1]};
      end
   end

endmodule

`default_nettype wire

/* src/uart_regs.sv */
// UART register block with transmit start, done flag and interrupt
`timescale 1ns/1ps
`default_nettype none
`include "soc_defines.svh"

module uart_regs
   import soc_bus_pkg::*;
   import soc_periph_pkg::*;
(
   input  wire          CPU_CLK,
   input  wire          rst_n,
   input  wire          req_valid,
   output logic         req_ready,
   input  wire fb_req_t req,
   output logic         rsp_valid,
   input  wire          rsp_ready,
   output fb_rsp_t      rsp,
   output logic         tx_start,
   output logic [7:0]   tx_byte,
   output logic [15:0]  div,
   input  wire          tx_busy,
   input  wire          tx_done,
   output logic         uart_irq
);

   reg_idx_e     idx;
   uart_status_t status;
   uart_ctrl_t   ctrl_q;
   logic         done_q;
   logic         acc;
   logic         wr;
   logic         wr_data;
   logic [31:0]  rd_word;

   assign req_ready = ~rsp_valid;  // Free when no response pending
   assign acc       = req_valid & req_ready;
   assign wr        = acc & (|req.wmsk);
   assign idx       = reg_idx_e'(req.addr.offset[`REG_IDX_W-1:0]);

   // Start pulse counts as busy until the engine picks it up
   assign status.busy    = tx_busy | tx_start;
   assign status.tx_done = done_q;
   assign wr_data        = wr & (idx == REG_DATA) & req.wmsk[0] & ~status.busy;
   assign uart_irq       = ctrl_q.irq_en & done_q;

   always_comb begin
      case (idx)
         REG_DATA:   rd_word = {24'd0, tx_byte};
         REG_STATUS: rd_word = {30'd0, status};
         REG_CTRL:   rd_word = {31'd0, ctrl_q};
         default:    rd_word = {16'd0, div};
      endcase
   end

   always_ff @(posedge CPU_CLK or negedge rst_n) begin
      if (!rst_n) begin
         rsp_valid <= 1'b0;
         tx_start  <= 1'b0;
         tx_byte   <= 8'd0;
         ctrl_q    <= '0;
         done_q    <= 1'b0;
         div       <= `UART_DIV_RST;
      end else begin
         tx_start <= wr_data;  // One-cycle pulse
         if (acc) begin
            rsp_valid <= 1'b1;
         end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
         end
         if (wr_data) begin
            tx_byte <= req.wdata[7:0];
         end
         if (wr & (idx == REG_CTRL) & req.wmsk[0]) begin
            ctrl_q.irq_en <= req.wdata[0];
         end
         if (wr & (idx == REG_DIV)) begin
            if (req.wmsk[0]) div[7:0]  <= req.wdata[7:0];   // Byte-masked
            if (req.wmsk[1]) div[15:8] <= req.wdata[15:8];
         end
         if (tx_done) begin
            done_q <= 1'b1;  // Set beats clear
         end else if (wr & (idx == REG_STATUS) & req.wmsk[0] & req.wdata[1]) begin
            done_q <= 1'b0;
         end
      end
   end

   // Read data captured at acceptance, held until taken
   always_ff @(posedge CPU_CLK) begin
      if (acc) begin
         rsp.rdata <= rd_word;
      end
   end

endmodule

`default_nettype wire

/* src/spi_shift.sv */
// SPI mode-0 clock generator and MSB-first shift engine
`timescale 1ns/1ps
`default_nettype none

module spi_shift (
   input  wire          CPU_CLK,
   input  wire          rst_n,
   input  wire          xfer_start,
   input  wire [7:0]    xfer_byte,
   input  wire [7:0]    div,
   input  wire          SPI_MISO,
   output logic         xfer_busy,
   output logic         xfer_done,
   output logic [7:0]   rx_byte,
   output logic         SPI_SCK,
   output logic         SPI_MOSI
);

   logic [7:0] half_cnt;   // Clocks in current half period
   logic [3:0] edge_cnt;   // 16 SCK edges per byte
   logic       half_end;

   assign half_end = xfer_busy & (half_cnt == div - 8'd1);

   always_ff @(posedge CPU_CLK or negedge rst_n) begin
      if (!rst_n) begin
         xfer_busy <= 1'b0;
         xfer_done <= 1'b0;
         half_cnt  <= 8'd0;
         edge_cnt  <= 4'd0;
         SPI_SCK   <= 1'b0;  // Mode 0 idles low
         SPI_MOSI  <= 1'b0;
      end else begin
         xfer_done <= 1'b0;
         if (~xfer_busy) begin
            if (xfer_start) begin
               xfer_busy <= 1'b1;
               half_cnt  <= 8'd0;
               edge_cnt  <= 4'd0;
               SPI_MOSI  <= xfer_byte[7];  // First bit before first rise
            end
         end else if (half_end) begin
            half_cnt <= 8'd0;
            SPI_SCK  <= ~SPI_SCK;
            edge_cnt <= edge_cnt + 4'd1;
            if (SPI_SCK) begin
               SPI_MOSI <= rx_byte[7];  // Falling edge
            end
            if (edge_cnt == 4'd15) begin
               xfer_busy <= 1'b0;
               xfer_done <= 1'b1;
            end
         end else begin
            half_cnt <= half_cnt + 8'd1;
         end
      end
   end

   // Outgoing bits leave at the top as MISO fills from the bottom
   always_ff @(posedge CPU_CLK) begin
      if (xfer_start & ~xfer_busy) begin
         rx_byte <= xfer_byte;
      end else if (half_end & ~SPI_SCK) begin
         rx_byte <= {rx_byte[6:0], SPI_MISO};  // Rising edge sample
      end
   end

endmodule

`default_nettype wire

/* src/spi_regs.sv */
// SPI register block with chip select control and transfer start
`timescale 1ns/1ps
`default_nettype none
`include "soc_defines.svh"

module spi_regs
   import soc_bus_pkg::*;
   import soc_periph_pkg::*;
(
   input  wire          CPU_CLK,
   input  wire          rst_n,
   input  wire          req_valid,
   output logic         req_ready,
   input  wire fb_req_t req,
   output logic         rsp_valid,
   input  wire          rsp_ready,
   output fb_rsp_t      rsp,
   output logic         xfer_start,
   output logic [7:0]   xfer_byte,
   output logic [7:0]   div,
   output logic         SPI_CS_L,
   input  wire          xfer_busy,
   input  wire          xfer_done,
   input  wire [7:0]    rx_byte
);

   reg_idx_e    idx;
   spi_status_t status;
   spi_ctrl_t   ctrl_q;
   logic [7:0]  rx_q;     // Last received byte
   logic        acc;
   logic        wr;
   logic        wr_data;
   logic [31:0] rd_word;

   assign req_ready   = ~rsp_valid;
   assign acc         = req_valid & req_ready;
   assign wr          = acc & (|req.wmsk);
   assign idx         = reg_idx_e'(req.addr.offset[`REG_IDX_W-1:0]);
   assign status.busy = xfer_busy | xfer_start;
   assign wr_data     = wr & (idx == REG_DATA) & req.wmsk[0] & ~status.busy;
   assign SPI_CS_L    = ~ctrl_q.cs_active;

   always_comb begin
      case (idx)
         REG_DATA:   rd_word = {24'd0, rx_q};
         REG_STATUS: rd_word = {31'd0, status};
         REG_CTRL:   rd_word = {31'd0, ctrl_q};
         default:    rd_word = {24'd0, div};
      endcase
   end

   always_ff @(posedge CPU_CLK or negedge rst_n) begin
      if (!rst_n) begin
         rsp_valid  <= 1'b0;
         xfer_start <= 1'b0;
         ctrl_q     <= '0;   // Chip select released
         rx_q       <= 8'd0;
         div        <= `SPI_DIV_RST;
      end else begin
         xfer_start <= wr_data;
         if (acc) begin
            rsp_valid <= 1'b1;
         end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
         end
         if (wr & (idx == REG_CTRL) & req.wmsk[0]) begin
            ctrl_q.cs_active <= req.wdata[0];
         end
         if (wr & (idx == REG_DIV) & req.wmsk[0]) begin
            div <= req.wdata[7:0];
         end
         if (xfer_done) begin
            rx_q <= rx_byte;
         end
      end
   end

   always_ff @(posedge CPU_CLK) begin
      if (wr_data) begin
         xfer_byte <= req.wdata[7:0];  // Held for the engine load
      end
      if (acc) begin
         rsp.rdata <= rd_word;
      end
   end

endmodule

`default_nettype wire

/* src/soc_mmio_top.sv */
// Peripheral subsystem top with reset synchronizer, router, SPI and UART
`timescale 1ns/1ps
`default_nettype none

module soc_mmio_top
   import soc_bus_pkg::*;
(
   input  wire          CPU_CLK,
   input  wire          RST_L,
   input  wire          req_valid,
   output logic         req_ready,
   input  wire fb_req_t req,
   output logic         rsp_valid,
   input  wire          rsp_ready,
   output fb_rsp_t      rsp,
   output logic         SPI_SCK,
   output logic         SPI_CS_L,
   output logic         SPI_MOSI,
   input  wire          SPI_MISO,
   output logic         UART_TX_L,
   output logic         uart_irq
);

   logic [1:0]  rst_q;
   logic        rst_n;
   logic        spi_req_valid;
   logic        spi_req_ready;
   logic        spi_rsp_valid;
   logic        spi_rsp_ready;
   fb_req_t     spi_req;
   fb_rsp_t     spi_rsp;
   logic        uart_req_valid;
   logic        uart_req_ready;
   logic        uart_rsp_valid;
   logic        uart_rsp_ready;
   fb_req_t     uart_req;
   fb_rsp_t     uart_rsp;
   logic        xfer_start;
   logic        xfer_busy;
   logic        xfer_done;
   logic [7:0]  xfer_byte;
   logic [7:0]  rx_byte;
   logic [7:0]  spi_div;
   logic        tx_start;
   logic        tx_busy;
   logic        tx_done;
   logic [7:0]  tx_byte;
   logic [15:0] uart_div;

   // Asserts asynchronously, releases two clocks after RST_L rises
   always_ff @(posedge CPU_CLK or negedge RST_L) begin
      if (!RST_L) begin
         rst_q <= 2'b00;
      end else begin
         rst_q <= {rst_q[0], 1'b1};
      end
   end
   assign rst_n = rst_q[1];

   pb_fb_router i_router (
      .CPU_CLK, .rst_n,
      .req_valid, .req_ready, .req, .rsp_valid, .rsp_ready, .rsp,
      .spi_req_valid, .spi_req_ready, .spi_req,
      .spi_rsp_valid, .spi_rsp_ready, .spi_rsp,
      .uart_req_valid, .uart_req_ready, .uart_req,
      .uart_rsp_valid, .uart_rsp_ready, .uart_rsp
   );

   spi_regs i_spi_regs (
      .CPU_CLK, .rst_n,
      .req_valid (spi_req_valid), .req_ready (spi_req_ready), .req (spi_req),
      .rsp_valid (spi_rsp_valid), .rsp_ready (spi_rsp_ready), .rsp (spi_rsp),
      .xfer_start, .xfer_byte, .div (spi_div), .SPI_CS_L,
      .xfer_busy, .xfer_done, .rx_byte
   );

   spi_shift i_spi_shift (
      .CPU_CLK, .rst_n, .xfer_start, .xfer_byte, .div (spi_div), .SPI_MISO,
      .xfer_busy, .xfer_done, .rx_byte, .SPI_SCK, .SPI_MOSI
   );

   uart_regs i_uart_regs (
      .CPU_CLK, .rst_n,
      .req_valid (uart_req_valid), .req_ready (uart_req_ready), .req (uart_req),
      .rsp_valid (uart_rsp_valid), .rsp_ready (uart_rsp_ready), .rsp (uart_rsp),
      .tx_start, .tx_byte, .div (uart_div), .tx_busy, .tx_done, .uart_irq
   );

   uart_tx i_uart_tx (
      .CPU_CLK, .rst_n, .tx_start, .tx_byte, .div (uart_div),
      .tx_busy, .tx_done, .UART_TX_L
   );

endmodule

`default_nettype wire

/* verification/tb_soc_mmio.sv */
// Directed testbench with clock, bus tasks, UART and SPI monitors and compare tasks
`timescale 1ns/1ps
`default_nettype none
`include "soc_defines.svh"

module tb_soc_mmio
   import soc_bus_pkg::*;
   import soc_periph_pkg::*;
();

   localparam int         WAIT_MAX = 2000;   // Cycles before a wait gives up
   localparam int         POLL_MAX = 100;    // Status reads before giving up
   localparam logic [3:0] MSK_ALL  = 4'hF;

   logic        CPU_CLK;
   logic        RST_L;
   logic        req_valid;
   logic        req_ready;
   fb_req_t     req;
   logic        rsp_valid;
   logic        rsp_ready;
   fb_rsp_t     rsp;
   logic        SPI_SCK;
   logic        SPI_CS_L;
   logic        SPI_MOSI;
   logic        SPI_MISO;
   logic        UART_TX_L;
   logic        uart_irq;

   integer      seed;
   int          checks;
   int          errors;
   int          timeouts;
   logic [15:0] uart_div_exp;   // Expected UART DIV contents
   logic [7:0]  spi_div_exp;    // Expected SPI DIV contents

   assign SPI_MISO = SPI_MOSI;  // Loopback

   soc_mmio_top i_soc_mmio_top (
      .CPU_CLK, .RST_L,
      .req_valid, .req_ready, .req, .rsp_valid, .rsp_ready, .rsp,
      .SPI_SCK, .SPI_CS_L, .SPI_MOSI, .SPI_MISO, .UART_TX_L, .uart_irq
   );

   always #10 CPU_CLK = ~CPU_CLK;  // 20 ns period

   task automatic check_rsp(input string name, input fb_rsp_t got, input fb_rsp_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t: %s got %h expected %h",
                  $time, name, got.rdata, exp.rdata);
      end
   endtask

   task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   function automatic fb_rsp_t rsp_word(input logic [31:0] d);
      fb_rsp_t r;
      r.rdata = d;
      return r;
   endfunction

   // Register address inside a region, index in addr[3:2]
   function automatic fb_addr_t reg_addr(input logic [7:0] region, input reg_idx_e idx);
      fb_addr_t a;
      a.region = region;
      a.offset = {20'd0, idx};
      a.lane   = 2'b00;
      return a;
   endfunction

   // Byte-lane write rule
   function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                               input logic [31:0] new_w,
                                               input logic [3:0]  msk);
      logic [31:0] m;
      m = old_w;
      for (int i = 0; i < 4; i++) begin
         if (msk[i]) m[8*i +: 8] = new_w[8*i +: 8];
      end
      return m;
   endfunction

   // Entered 1 ns after a rising edge, left the same way
   task automatic send_req(input fb_addr_t addr, input logic [3:0] wmsk,
                           input logic [31:0] wdata);
      int n;
      n         = 0;
      req_valid = 1'b1;
      req.addr  = addr;
      req.wmsk  = wmsk;
      req.wdata = wdata;
      @(negedge CPU_CLK);
      while (!req_ready && n < WAIT_MAX) begin
         @(negedge CPU_CLK);
         n++;
      end
      if (!req_ready) begin
         timeouts++;
         $display("Timeout: request to %h was never accepted", addr);
      end
      @(posedge CPU_CLK);  // Transfer edge
      #1;
      req_valid = 1'b0;
      req       = '0;
   endtask

   // Returns at the falling edge where rsp_valid is seen
   task automatic wait_rsp_valid(output fb_rsp_t r);
      int n;
      n = 0;
      @(negedge CPU_CLK);
      while (!rsp_valid && n < WAIT_MAX) begin
         @(negedge CPU_CLK);
         n++;
      end
      if (!rsp_valid) begin
         timeouts++;
         $display("Timeout: no response arrived");
      end
      r = rsp;
   endtask

   task automatic bus_read(input fb_addr_t addr, output fb_rsp_t r);
      send_req(addr, 4'h0, 32'd0);
      wait_rsp_valid(r);
      @(posedge CPU_CLK);
      #1;
   endtask

   task automatic bus_write(input fb_addr_t addr, input logic [3:0] msk, input logic [31:0] d);
      fb_rsp_t r;
      send_req(addr, msk, d);
      wait_rsp_valid(r);
      @(posedge CPU_CLK);
      #1;
   endtask

   // Samples each UART bit near its middle
   task automatic uart_monitor(input int div, output logic [7:0] data);
      int n;
      n    = 0;
      data = 8'h00;
      @(negedge CPU_CLK);
      while (UART_TX_L && n < WAIT_MAX) begin
         @(negedge CPU_CLK);
         n++;
      end
      if (UART_TX_L) begin
         timeouts++;
         $display("Timeout: no UART start bit seen");
      end else begin
         repeat (div / 2) @(negedge CPU_CLK);
         check_bit("UART_TX_L start bit", UART_TX_L, 1'b0);
         for (int i = 0; i < 8; i++) begin
            repeat (div) @(negedge CPU_CLK);
            data[i] = UART_TX_L;  // LSB first
         end
         repeat (div) @(negedge CPU_CLK);
         check_bit("UART_TX_L stop bit", UART_TX_L, 1'b1);
      end
      @(posedge CPU_CLK);
      #1;
   endtask

   // Samples SPI_MOSI after each SCK rise and times the SCK period
   task automatic spi_monitor(output logic [7:0] data);
      int         n;
      int         bits;
      int         last;
      logic       sck_prev;
      logic [7:0] period;
      n        = 0;
      bits     = 0;
      last     = 0;
      data     = 8'h00;
      sck_prev = SPI_SCK;
      while (bits < 8 && n < WAIT_MAX) begin
         @(negedge CPU_CLK);
         n++;
         if (SPI_SCK && !sck_prev) begin
            if (bits > 0) begin
               period = 8'(n - last);
               check_byte("SPI_SCK period", period, {spi_div_exp[6:0], 1'b0});  // Two halves
            end
            data = {data[6:0], SPI_MOSI};  // MSB first
            last = n;
            bits++;
         end
         sck_prev = SPI_SCK;
      end
      if (bits < 8) begin
         timeouts++;
         $display("Timeout: SPI_SCK stopped before 8 rising edges");
      end
   endtask

   task automatic set_uart_div(input logic [31:0] d, input logic [3:0] msk);
      logic [31:0] m;
      m            = merge_bytes({16'd0, uart_div_exp}, d, msk);
      uart_div_exp = m[15:0];
      bus_write(reg_addr(`UART_REGION, REG_DIV), msk, d);
   endtask

   task automatic set_spi_div(input logic [31:0] d, input logic [3:0] msk);
      logic [31:0] m;
      m           = merge_bytes({24'd0, spi_div_exp}, d, msk);
      spi_div_exp = m[7:0];  // 8-bit register
      bus_write(reg_addr(`SPI_REGION, REG_DIV), msk, d);
   endtask

   task automatic check_divs(input string when);
      fb_rsp_t r;
      bus_read(reg_addr(`UART_REGION, REG_DIV), r);
      check_rsp({"UART DIV ", when}, r, rsp_word({16'd0, uart_div_exp}));
      bus_read(reg_addr(`SPI_REGION, REG_DIV), r);
      check_rsp({"SPI DIV ", when}, r, rsp_word({24'd0, spi_div_exp}));
   endtask

   task automatic apply_reset();
      RST_L = 1'b0;
      @(negedge CPU_CLK);
      check_bit("req_ready in reset", req_ready, 1'b0);
      check_bit("rsp_valid in reset", rsp_valid, 1'b0);
      repeat (2) @(posedge CPU_CLK);
      #1;
      RST_L = 1'b1;
   endtask

   task automatic reset_test();
      check_bit("UART_TX_L after reset", UART_TX_L, 1'b1);
      check_bit("SPI_CS_L after reset", SPI_CS_L, 1'b1);
      check_bit("SPI_SCK after reset", SPI_SCK, 1'b0);
      check_bit("uart_irq after reset", uart_irq, 1'b0);
      check_divs("after reset");
   endtask

   task automatic reg_mask_test();
      set_uart_div(32'h0000_2A5C, MSK_ALL);
      set_spi_div(32'h0000_0033, MSK_ALL);
      check_divs("full mask");
      set_uart_div(32'h0000_C3FF, 4'b0010);  // High byte only
      set_spi_div(32'h0000_7700, 4'b0010);   // No SPI lane hit
      check_divs("partial mask");
      set_spi_div(32'hFFFF_FF66, 4'b0001);
      check_divs("low lane");
   endtask

   task automatic uart_tx_test();
      logic [31:0]  rnd;
      logic [7:0]   b;
      logic [7:0]   got;
      fb_rsp_t      r;
      uart_status_t st;
      int           n;
      set_uart_div(32'd8, MSK_ALL);
      bus_write(reg_addr(`UART_REGION, REG_CTRL), MSK_ALL, 32'd1);  // irq_en
      rnd = $random(seed);
      b   = rnd[7:0];
      bus_write(reg_addr(`UART_REGION, REG_DATA), MSK_ALL, {24'd0, b});
      fork
         uart_monitor(8, got);
         begin
            bus_read(reg_addr(`UART_REGION, REG_STATUS), r);
            st.busy    = 1'b1;
            st.tx_done = 1'b0;
            check_rsp("UART STATUS in frame", r, rsp_word({30'd0, st}));
            check_bit("uart_irq in frame", uart_irq, 1'b0);
         end
      join
      check_byte("UART_TX_L data", got, b);
      n = 0;
      bus_read(reg_addr(`UART_REGION, REG_STATUS), r);
      while (!r.rdata[1] && n < POLL_MAX) begin  // Wait for tx_done
         bus_read(reg_addr(`UART_REGION, REG_STATUS), r);
         n++;
      end
      if (!r.rdata[1]) begin
         timeouts++;
         $display("Timeout: UART tx_done never set");
      end
      st.busy    = 1'b0;
      st.tx_done = 1'b1;
      check_rsp("UART STATUS after frame", r, rsp_word({30'd0, st}));
      check_bit("uart_irq after frame", uart_irq, 1'b1);
      bus_write(reg_addr(`UART_REGION, REG_STATUS), MSK_ALL, 32'h2);  // Clear tx_done
      check_bit("uart_irq after clear", uart_irq, 1'b0);
      bus_read(reg_addr(`UART_REGION, REG_STATUS), r);
      check_rsp("UART STATUS after clear", r, rsp_word(32'd0));
   endtask

   task automatic spi_loop_test();
      logic [31:0] rnd;
      logic [7:0]  b;
      logic [7:0]  mosi;
      fb_rsp_t     r;
      int          n;
      set_spi_div(32'd4, MSK_ALL);
      bus_write(reg_addr(`SPI_REGION, REG_CTRL), MSK_ALL, 32'd1);
      check_bit("SPI_CS_L selected", SPI_CS_L, 1'b0);
      rnd = $random(seed);
      b   = rnd[7:0];
      bus_write(reg_addr(`SPI_REGION, REG_DATA), MSK_ALL, {24'd0, b});
      fork
         spi_monitor(mosi);
         begin
            bus_read(reg_addr(`SPI_REGION, REG_STATUS), r);
            check_rsp("SPI STATUS after start", r, rsp_word(32'd1));
            n = 0;
            while (r.rdata[0] && n < POLL_MAX) begin  // Until busy clears
               bus_read(reg_addr(`SPI_REGION, REG_STATUS), r);
               n++;
            end
            if (r.rdata[0]) begin
               timeouts++;
               $display("Timeout: SPI busy never cleared");
            end
         end
      join
      check_byte("SPI_MOSI data", mosi, b);
      check_bit("SPI_SCK after byte", SPI_SCK, 1'b0);
      bus_read(reg_addr(`SPI_REGION, REG_DATA), r);
      check_byte("SPI DATA loopback", r.rdata[7:0], b);
      bus_write(reg_addr(`SPI_REGION, REG_CTRL), MSK_ALL, 32'd0);
      check_bit("SPI_CS_L released", SPI_CS_L, 1'b1);
   endtask

   task automatic unmapped_test();
      fb_rsp_t r;
      bus_read(reg_addr(8'h00, REG_DIV), r);
      check_rsp("region 00 read", r, rsp_word(32'd0));
      bus_read(reg_addr(8'h82, REG_DIV), r);
      check_rsp("region 82 read", r, rsp_word(32'd0));
      bus_write(reg_addr(8'h82, REG_DIV), MSK_ALL, 32'hFFFF_FFFF);
      bus_write(reg_addr(8'h00, REG_DIV), MSK_ALL, 32'hFFFF_FFFF);
      bus_write(reg_addr(8'h82, REG_CTRL), MSK_ALL, 32'd1);
      check_bit("SPI_CS_L after unmapped write", SPI_CS_L, 1'b1);
      check_divs("after unmapped writes");
   endtask

   task automatic backpressure_test();
      fb_rsp_t first;
      rsp_ready = 1'b0;
      send_req(reg_addr(`UART_REGION, REG_DIV), 4'h0, 32'd0);
      wait_rsp_valid(first);
      check_rsp("held rsp", first, rsp_word({16'd0, uart_div_exp}));
      repeat (5) begin
         @(negedge CPU_CLK);
         check_bit("rsp_valid under stall", rsp_valid, 1'b1);
         check_rsp("rsp under stall", rsp, rsp_word({16'd0, uart_div_exp}));
         check_bit("req_ready under stall", req_ready, 1'b0);
      end
      @(posedge CPU_CLK);
      #1;
      rsp_ready = 1'b1;
      @(negedge CPU_CLK);
      check_bit("rsp_valid at release", rsp_valid, 1'b1);
      check_rsp("rsp at release", rsp, rsp_word({16'd0, uart_div_exp}));
      @(posedge CPU_CLK);  // Response taken here
      #1;
      check_bit("rsp_valid after transfer", rsp_valid, 1'b0);
   endtask

   initial begin
      seed         = 32'hc5fa;
      checks       = 0;
      errors       = 0;
      timeouts     = 0;
      uart_div_exp = `UART_DIV_RST;
      spi_div_exp  = `SPI_DIV_RST;
      CPU_CLK      = 1'b0;
      RST_L        = 1'b0;
      req_valid    = 1'b0;
      req          = '0;
      rsp_ready    = 1'b1;
      apply_reset();
      reset_test();
      reg_mask_test();
      uart_tx_test();
      spi_loop_test();
      unmapped_test();
      backpressure_test();
      $display("Checks: %0d  errors: %0d  timeouts: %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* soc_mmio.f */
+incdir+src
src/soc_bus_pkg.sv
src/soc_periph_pkg.sv
src/pb_fb_router.sv
src/uart_tx.sv
src/uart_regs.sv
src/spi_shift.sv
src/spi_regs.sv
src/soc_mmio_top.sv
verification/tb_soc_mmio.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then grep the log for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module tb_soc_mmio \
   -f soc_mmio.f --Mdir obj_dir -o sim_soc_mmio > build.log 2>&1 &&
./obj_dir/sim_soc_mmio > sim.log 2>&1 ||
{ echo "Build or simulation error, see build.log and sim.log"; exit 1; }

cat sim.log
grep -q "^Result: PASSED$" sim.log && exit 0 || exit 1
